// File: Bender.yml
package:
  name: mem_tile

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - common/noc_pkg.sv
      - source/stream_fifo.sv
      - source/noc_endpoint.sv
      - atop_resolver/atop_resolver.sv
      - sram_bank/sram_macro.sv
      - sram_bank/sram_banks.sv
      - source/mem_tile.sv
      - target: test
        files:
          - dv/tb_mem_tile.sv

// File: atop_resolver/atop_resolver.sv
// Atomic operation resolver
// Runs AMOs and LR/SC as read then write on the bank side,
// plain reads and writes pass straight through

`include "mem_tile_config.svh"
`default_nettype none

module atop_resolver
  import noc_pkg::*;
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     sbr_req_i,
  output logic     sbr_gnt_o,
  input  mem_req_t sbr_req_data_i,
  output logic     sbr_rvalid_o,
  output mem_rsp_t sbr_rsp_o,
  output logic     mgr_req_o,
  input  logic     mgr_gnt_i,
  output mem_req_t mgr_req_data_o,
  input  logic     mgr_rvalid_i,
  input  mem_rsp_t mgr_rsp_i
);

  localparam int unsigned LaneW = 32;
  localparam int unsigned StrbW = `MEM_TILE_DATA_W / 8;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } state_e;

  state_e           state_q;
  mem_req_t         op_q;
  logic [LaneW-1:0] old_q, old_lane, operand, amo_res, rsp_lane;
  logic             sc_fail_q, sc_fail, is_amo, is_sc, lane_hi, accept;
  logic             resv_valid_q;
  word_addr_t       resv_addr_q;
  id_t              resv_src_q;

  assign is_amo  = sbr_req_data_i.atop != atop_none;
  assign is_sc   = sbr_req_data_i.atop == atop_sc;
  assign sc_fail = is_sc & ~(resv_valid_q & (resv_addr_q == sbr_req_data_i.addr) &
                             (resv_src_q == sbr_req_data_i.src_id));

  // Failed SC needs no bank access
  assign sbr_gnt_o = (state_q == st_idle) & (mgr_gnt_i | sc_fail);
  assign accept    = sbr_req_i & sbr_gnt_o;

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign lane_hi  = |op_q.be[StrbW-1:StrbW/2];
  assign old_lane = lane_hi ? mgr_rsp_i.rdata[2*LaneW-1:LaneW] : mgr_rsp_i.rdata[LaneW-1:0];
  assign operand  = lane_hi ? op_q.wdata[2*LaneW-1:LaneW] : op_q.wdata[LaneW-1:0];

  always_comb begin
    case (op_q.atop)
      atop_swap, atop_sc: amo_res = operand;
      atop_add:  amo_res = old_lane + operand;
      atop_and:  amo_res = old_lane & operand;
      atop_or:   amo_res = old_lane | operand;
      atop_xor:  amo_res = old_lane ^ operand;
      atop_max:  amo_res = ($signed(old_lane) > $signed(operand)) ? old_lane : operand;
      atop_min:  amo_res = ($signed(old_lane) < $signed(operand)) ? old_lane : operand;
      atop_maxu: amo_res = (old_lane > operand) ? old_lane : operand;
      atop_minu: amo_res = (old_lane < operand) ? old_lane : operand;
      default:   amo_res = old_lane;
    endcase
  end

  //////////////////////////////
  // Bank side
  //////////////////////////////

  always_comb begin
    mgr_req_o           = 1'b0;
    mgr_req_data_o      = sbr_req_data_i;
    mgr_req_data_o.atop = atop_none;
    mgr_req_data_o.we   = sbr_req_data_i.we & ~is_amo;
    case (state_q)
      st_idle: mgr_req_o = sbr_req_i & ~sc_fail;
      st_read: begin
        // Write back the result, LR only reads
        mgr_req_o            = op_q.atop != atop_lr;
        mgr_req_data_o       = op_q;
        mgr_req_data_o.atop  = atop_none;
        mgr_req_data_o.we    = 1'b1;
        mgr_req_data_o.wdata = {(`MEM_TILE_DATA_W / LaneW){amo_res}};
      end
      default: ;
    endcase
  end

  // Response, old value zero-extended in its lane
  always_comb begin
    rsp_lane = old_q;
    if (op_q.atop == atop_sc) begin
      rsp_lane = {{(LaneW - 1){1'b0}}, sc_fail_q};
    end
    sbr_rvalid_o = (state_q == st_idle) ? mgr_rvalid_i : (state_q == st_write);
    sbr_rsp_o    = mgr_rsp_i;
    if (state_q == st_write) begin
      sbr_rsp_o.rdata = lane_hi ? {rsp_lane, {LaneW{1'b0}}} : {{LaneW{1'b0}}, rsp_lane};
      sbr_rsp_o.err   = sc_fail_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= st_idle;
      resv_valid_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept && is_amo) begin
            state_q <= sc_fail ? st_write : st_read;
          end
        end
        st_read: state_q <= st_write;
        default: state_q <= st_idle;
      endcase
      // Any SC or write to the reserved word drops the reservation
      if (accept && sbr_req_data_i.atop == atop_lr) begin
        resv_valid_q <= 1'b1;
      end else if ((accept && is_sc) || (mgr_req_o && mgr_gnt_i && mgr_req_data_o.we &&
                   mgr_req_data_o.addr == resv_addr_q)) begin
        resv_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_amo) begin
      op_q      <= sbr_req_data_i;
      sc_fail_q <= sc_fail;
    end
    if (accept && sbr_req_data_i.atop == atop_lr) begin
      resv_addr_q <= sbr_req_data_i.addr;
      resv_src_q  <= sbr_req_data_i.src_id;
    end
    if (state_q == st_read) begin
      old_q <= old_lane;
    end
  end

endmodule

`default_nettype wire

// File: common/mem_pkg.sv
// Memory bus package
// Request and response types of the tile internal memory bus,
// and the atomic operations it carries

`include "mem_tile_config.svh"
`default_nettype none

package mem_pkg;

  typedef enum logic [3:0] {
    atop_none,
    atop_swap,
    atop_add,
    atop_and,
    atop_or,
    atop_xor,
    atop_max,
    atop_min,
    atop_maxu,
    atop_minu,
    atop_lr,
    atop_sc
  } atop_e;

  // Address of one bus word
  typedef logic [`MEM_TILE_ADDR_W-$clog2(`MEM_TILE_DATA_W/8)-1:0] word_addr_t;

  typedef struct packed {
    word_addr_t                     addr;
    logic                           we;
    logic [`MEM_TILE_DATA_W-1:0]    wdata;
    logic [`MEM_TILE_DATA_W/8-1:0]  be;
    atop_e                          atop;
    logic [`MEM_TILE_ID_W-1:0]      src_id;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_TILE_DATA_W-1:0] rdata;
    logic                        err;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: common/mem_tile_config.svh
// Memory tile configuration
// Bus widths, SRAM bank geometry, id widths and endpoint buffering

`ifndef MEM_TILE_CONFIG_SVH
`define MEM_TILE_CONFIG_SVH

`define MEM_TILE_DATA_W          64
`define MEM_TILE_ADDR_W          32
`define MEM_TILE_SRAM_DATA_W     32
`define MEM_TILE_BANKS_PER_WORD  2
`define MEM_TILE_BANK_ROWS       4
`define MEM_TILE_SRAM_WORDS      64

`define MEM_TILE_ID_W            4
`define MEM_TILE_TXN_W           4
`define MEM_TILE_FIFO_DEPTH      2

// Tile capacity in bytes
`define MEM_TILE_BYTES (`MEM_TILE_SRAM_WORDS * `MEM_TILE_BANK_ROWS * `MEM_TILE_DATA_W / 8)

`endif

// File: common/noc_pkg.sv
// Network port package
// Flit formats and opcodes seen on the tile ejection port

`include "mem_tile_config.svh"
`default_nettype none

package noc_pkg;

  typedef logic [`MEM_TILE_ID_W-1:0]  id_t;
  typedef logic [`MEM_TILE_TXN_W-1:0] txn_t;

  typedef enum logic [1:0] {
    noc_read,
    noc_write,
    noc_atomic
  } noc_op_e;

  // Atomic kind only meaningful with noc_atomic
  typedef struct packed {
    id_t                            dst_id;
    id_t                            src_id;
    txn_t                           txn_id;
    noc_op_e                        op;
    mem_pkg::atop_e                 atop;
    logic [`MEM_TILE_ADDR_W-1:0]    addr;
    logic [`MEM_TILE_DATA_W-1:0]    wdata;
    logic [`MEM_TILE_DATA_W/8-1:0]  be;
  } noc_req_flit_t;

  typedef struct packed {
    id_t                          dst_id;
    id_t                          src_id;
    txn_t                         txn_id;
    logic [`MEM_TILE_DATA_W-1:0]  rdata;
    logic                         err;
  } noc_rsp_flit_t;

endpackage

`default_nettype wire

// File: dv/tb_mem_tile.sv
// Memory tile testbench
// Table of network requests with expected responses, applied in order,
// checked by a response monitor, random back-pressure in the last test

`include "mem_tile_config.svh"
`default_nettype none

module tb_mem_tile
  import noc_pkg::*;
  import mem_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam id_t TileId       = 4'h5;
  localparam id_t SrcA         = 4'h1;
  localparam id_t SrcB         = 4'h2;
  localparam int  ReadyTimeout = 100;
  localparam int  DrainTimeout = 300;

  typedef struct packed {
    logic [2:0]    test;
    noc_op_e       op;
    atop_e         atop;
    id_t           src;
    txn_t          txn;
    logic [31:0]   addr;
    logic [63:0]   wdata;
    logic [7:0]    be;
    logic [63:0]   exp_data;
    logic          exp_err;
    logic          chk_data;
  } entry_t;

  logic          clk_i, rst_n_i;
  id_t           id_i;
  logic          req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
  noc_req_flit_t req_flit_i;
  noc_rsp_flit_t rsp_flit_o;

  entry_t      stim_q [$];
  logic [63:0] shadow_q [256];
  logic        resv_valid;
  logic [7:0]  resv_word;
  id_t         resv_src;
  logic [31:0] lfsr_q = 32'h022d_e107;
  logic        bp_en, timed_out;
  int          tx_idx, rx_idx, checks_n, errors_n;
  int          test_errs [1:6];
  string       test_names [1:6] = '{"write/read byte enables", "macro rows", "amo ops",
                                    "lr/sc", "out of range", "back-pressure"};

  mem_tile i_mem_tile (
    .clk_i,
    .rst_n_i,
    .id_i,
    .req_valid_i,
    .req_flit_i,
    .req_ready_o,
    .rsp_valid_o,
    .rsp_flit_o,
    .rsp_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[62:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] amo_result(input atop_e op, input logic [31:0] mem_v,
                                             input logic [31:0] opd);
    case (op)
      atop_swap: return opd;
      atop_add:  return mem_v + opd;
      atop_and:  return mem_v & opd;
      atop_or:   return mem_v | opd;
      atop_xor:  return mem_v ^ opd;
      atop_max:  return ($signed(mem_v) >= $signed(opd)) ? mem_v : opd;
      atop_min:  return ($signed(mem_v) <= $signed(opd)) ? mem_v : opd;
      atop_maxu: return (mem_v >= opd) ? mem_v : opd;
      atop_minu: return (mem_v <= opd) ? mem_v : opd;
      default:   return mem_v;
    endcase
  endfunction

  // Appends one request and updates the memory model
  task automatic add_entry(input int test, input noc_op_e op, input atop_e atop, input id_t src,
                           input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [7:0] be);
    entry_t      e;
    logic [7:0]  word;
    logic [31:0] old_v, opd, new_v, rsp_v;
    logic        sc_ok;
    word       = addr[10:3];
    e          = '0;
    e.test     = 3'(test);
    e.op       = op;
    e.atop     = atop;
    e.src      = src;
    e.txn      = 4'(stim_q.size());
    e.addr     = addr;
    e.wdata    = wdata;
    e.be       = be;
    e.chk_data = 1'b1;
    if (addr >= `MEM_TILE_BYTES) begin
      e.exp_err = 1'b1;
    end else if (op == noc_write) begin
      e.chk_data = 1'b0;
      for (int b = 0; b < 8; b++) begin
        if (be[b]) shadow_q[word][b*8+:8] = wdata[b*8+:8];
      end
      if (resv_valid && resv_word == word) resv_valid = 1'b0;
    end else if (op == noc_read) begin
      e.exp_data = shadow_q[word];
    end else begin
      old_v = addr[2] ? shadow_q[word][63:32] : shadow_q[word][31:0];
      opd   = addr[2] ? wdata[63:32] : wdata[31:0];
      new_v = old_v;
      rsp_v = old_v;
      if (atop == atop_lr) begin
        resv_valid = 1'b1;
        resv_word  = word;
        resv_src   = src;
      end else if (atop == atop_sc) begin
        sc_ok      = resv_valid && resv_word == word && resv_src == src;
        resv_valid = 1'b0;
        rsp_v      = sc_ok ? 32'd0 : 32'd1;
        e.exp_err  = !sc_ok;
        if (sc_ok) new_v = opd;
      end else begin
        new_v = amo_result(atop, old_v, opd);
        if (resv_valid && resv_word == word) resv_valid = 1'b0;
      end
      if (addr[2]) begin
        shadow_q[word][63:32] = new_v;
        e.exp_data            = {rsp_v, 32'h0};
      end else begin
        shadow_q[word][31:0] = new_v;
        e.exp_data           = {32'h0, rsp_v};
      end
    end
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    atop_e       kinds [9] = '{atop_swap, atop_add, atop_and, atop_or, atop_xor,
                               atop_max, atop_min, atop_maxu, atop_minu};
    logic [31:0] olds [9]  = '{32'h1234_5678, 32'hffff_fff0, 32'hf0f0_f0f0, 32'h0f0f_0000,
                               32'haaaa_5555, 32'hffff_fff0, 32'hffff_fff0, 32'hffff_fff0,
                               32'hffff_fff0};
    logic [31:0] opds [9]  = '{32'hcafe_f00d, 32'h0000_0020, 32'hff00_ff00, 32'h0000_f0f0,
                               32'hffff_0000, 32'h0000_0005, 32'h0000_0005, 32'h0000_0005,
                               32'h0000_0005};
    logic [31:0] a;
    logic [63:0] rnd, data;
    resv_valid = 1'b0;
    // Full and partial byte enables in both lanes
    add_entry(1, noc_write, atop_none, SrcA, 32'h010, 64'h1122_3344_5566_7788, 8'hff);
    add_entry(1, noc_read,  atop_none, SrcA, 32'h010, '0, 8'hff);
    add_entry(1, noc_write, atop_none, SrcA, 32'h010, 64'haaaa_bbbb_cccc_dddd, 8'h05);
    add_entry(1, noc_write, atop_none, SrcA, 32'h010, 64'heeee_ffff_0000_1111, 8'h90);
    add_entry(1, noc_read,  atop_none, SrcA, 32'h010, '0, 8'hff);
    add_entry(1, noc_write, atop_none, SrcA, 32'h020, 64'h0102_0304_0506_0708, 8'hff);
    add_entry(1, noc_write, atop_none, SrcA, 32'h020, 64'h9999_9999_9999_9999, 8'h3c);
    add_entry(1, noc_read,  atop_none, SrcA, 32'h020, '0, 8'hff);
    // One word per macro row, same macro offset
    for (int r = 0; r < 4; r++) begin
      add_entry(2, noc_write, atop_none, SrcA, 32'h028 + 32'h200 * r,
                64'h1000_0000_0000_0001 * (r + 1), 8'hff);
    end
    for (int r = 3; r >= 0; r--) begin
      add_entry(2, noc_read, atop_none, SrcA, 32'h028 + 32'h200 * r, '0, 8'hff);
    end
    // Each AMO on alternating lanes
    for (int k = 0; k < 9; k++) begin
      a = 32'h100 + 8 * k + 4 * (k % 2);
      add_entry(3, noc_write, atop_none, SrcA, a,
                (k % 2) ? {olds[k], 32'h5a5a_5a5a} : {32'h5a5a_5a5a, olds[k]}, 8'hff);
      add_entry(3, noc_atomic, kinds[k], SrcA, a, {2{opds[k]}}, 8'hff);
      add_entry(3, noc_read, atop_none, SrcA, a, '0, 8'hff);
    end
    // LR/SC success, then failure by write and by foreign source
    add_entry(4, noc_write,  atop_none, SrcA, 32'h300, 64'h0000_0000_1111_1111, 8'hff);
    add_entry(4, noc_atomic, atop_lr,   SrcA, 32'h300, '0, 8'hff);
    add_entry(4, noc_atomic, atop_sc,   SrcA, 32'h300, {2{32'h2222_2222}}, 8'hff);
    add_entry(4, noc_read,   atop_none, SrcA, 32'h300, '0, 8'hff);
    add_entry(4, noc_atomic, atop_lr,   SrcA, 32'h304, '0, 8'hff);
    add_entry(4, noc_write,  atop_none, SrcB, 32'h300, 64'h0000_0000_3333_3333, 8'h0f);
    add_entry(4, noc_atomic, atop_sc,   SrcA, 32'h304, {2{32'h4444_4444}}, 8'hff);
    add_entry(4, noc_read,   atop_none, SrcA, 32'h300, '0, 8'hff);
    add_entry(4, noc_atomic, atop_lr,   SrcA, 32'h300, '0, 8'hff);
    add_entry(4, noc_atomic, atop_sc,   SrcB, 32'h300, {2{32'h5555_5555}}, 8'hff);
    add_entry(4, noc_read,   atop_none, SrcA, 32'h300, '0, 8'hff);
    // 0x808 would alias word 1 if it reached the banks
    add_entry(5, noc_write, atop_none, SrcA, 32'h008, 64'h7777_6666_5555_4444, 8'hff);
    add_entry(5, noc_write, atop_none, SrcB, 32'h808, 64'hdead_beef_dead_beef, 8'hff);
    add_entry(5, noc_read,  atop_none, SrcA, 32'hffff_fff8, '0, 8'hff);
    add_entry(5, noc_atomic, atop_swap, SrcA, 32'h800, {2{32'h1}}, 8'hff);
    add_entry(5, noc_read,  atop_none, SrcA, 32'h008, '0, 8'hff);
    // Random write/read pairs, sent back to back
    for (int i = 0; i < 8; i++) begin
      draw_bits(8, rnd);
      draw_bits(64, data);
      a = {21'h0, rnd[7:0], 3'b000};
      add_entry(6, noc_write, atop_none, SrcA, a, data, 8'hff);
      add_entry(6, noc_read,  atop_none, SrcB, a, '0, 8'hff);
    end
  endtask

  //////////////////////////////
  // Driver and monitor
  //////////////////////////////

  always @(negedge clk_i) begin
    if (bp_en) begin
      lfsr_q      = lfsr_next(lfsr_q);
      rsp_ready_i = lfsr_q[0];
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp, input int test);
    checks_n++;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors_n++;
      test_errs[test]++;
    end
  endtask

  always @(posedge clk_i) begin : monitor_rsp
    entry_t e;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      assert (rx_idx < stim_q.size()) else begin
        $display("A response flit arrived with no request left to match it");
        errors_n++;
      end
      if (rx_idx < stim_q.size()) begin
        e = stim_q[rx_idx];
        check_value("rsp_flit_o.txn_id", rsp_flit_o.txn_id, e.txn, e.test);
        check_value("rsp_flit_o.dst_id", rsp_flit_o.dst_id, e.src, e.test);
        check_value("rsp_flit_o.src_id", rsp_flit_o.src_id, TileId, e.test);
        if (e.chk_data) check_value("rsp_flit_o.rdata", rsp_flit_o.rdata, e.exp_data, e.test);
        check_value("rsp_flit_o.err", rsp_flit_o.err, e.exp_err, e.test);
      end
      rx_idx++;
    end
  end

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_entry(input entry_t e);
    int cycles;
    cycles             = 0;
    req_flit_i         = '0;
    req_flit_i.dst_id  = TileId;
    req_flit_i.src_id  = e.src;
    req_flit_i.txn_id  = e.txn;
    req_flit_i.op      = e.op;
    req_flit_i.atop    = e.atop;
    req_flit_i.addr    = e.addr;
    req_flit_i.wdata   = e.wdata;
    req_flit_i.be      = e.be;
    req_valid_i        = 1'b1;
    while (!req_ready_o && cycles < ReadyTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!req_ready_o) begin
      $display("Timeout: req_ready_o stayed low for %0d cycles before txn %0d", cycles, e.txn);
      timed_out = 1'b1;
    end else begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_test(input int t);
    int cycles;
    @(posedge clk_i);
    bp_en = (t == 6);
    @(negedge clk_i);
    while (tx_idx < stim_q.size() && stim_q[tx_idx].test == t && !timed_out) begin
      send_entry(stim_q[tx_idx]);
      tx_idx++;
    end
    req_valid_i = 1'b0;
    cycles      = 0;
    while (rx_idx < tx_idx && cycles < DrainTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (rx_idx < tx_idx) begin
      $display("Timeout: %0d responses still missing in test %0d", tx_idx - rx_idx, t);
      timed_out = 1'b1;
    end
    $display("Test %0d %s: %0d errors", t, test_names[t], test_errs[t]);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    id_i        = TileId;
    req_valid_i = 1'b0;
    req_flit_i  = '0;
    rsp_ready_i = 1'b1;
    bp_en       = 1'b0;
    timed_out   = 1'b0;
    build_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int t = 1; t <= 6; t++) begin
      if (!timed_out) run_test(t);
    end
    $display("Checks: %0d, errors: %0d", checks_n, errors_n);
    if (errors_n == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/mem_tile.sv
// Memory tile top
// Network endpoint, atomic resolver and banked SRAM in series

`default_nettype none

module mem_tile
  import noc_pkg::*;
  import mem_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  id_t           id_i,
  input  logic          req_valid_i,
  input  noc_req_flit_t req_flit_i,
  output logic          req_ready_o,
  output logic          rsp_valid_o,
  output noc_rsp_flit_t rsp_flit_o,
  input  logic          rsp_ready_i
);

  logic     ep_req, ep_gnt, ep_rvalid;
  mem_req_t ep_req_data;
  mem_rsp_t ep_rsp;

  logic     bank_req, bank_gnt, bank_rvalid;
  mem_req_t bank_req_data;
  mem_rsp_t bank_rsp;

  noc_endpoint i_noc_endpoint (
    .clk_i,
    .rst_n_i,
    .id_i,
    .req_valid_i,
    .req_ready_o,
    .req_flit_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_flit_o,
    .mem_req_o     (ep_req),
    .mem_gnt_i     (ep_gnt),
    .mem_req_data_o(ep_req_data),
    .mem_rvalid_i  (ep_rvalid),
    .mem_rsp_i     (ep_rsp)
  );

  atop_resolver i_atop_resolver (
    .clk_i,
    .rst_n_i,
    .sbr_req_i     (ep_req),
    .sbr_gnt_o     (ep_gnt),
    .sbr_req_data_i(ep_req_data),
    .sbr_rvalid_o  (ep_rvalid),
    .sbr_rsp_o     (ep_rsp),
    .mgr_req_o     (bank_req),
    .mgr_gnt_i     (bank_gnt),
    .mgr_req_data_o(bank_req_data),
    .mgr_rvalid_i  (bank_rvalid),
    .mgr_rsp_i     (bank_rsp)
  );

  sram_banks i_sram_banks (
    .clk_i,
    .rst_n_i,
    .req_i     (bank_req),
    .gnt_o     (bank_gnt),
    .req_data_i(bank_req_data),
    .rvalid_o  (bank_rvalid),
    .rsp_o     (bank_rsp)
  );

endmodule

`default_nettype wire

// File: source/noc_endpoint.sv
// Network endpoint
// Unpacks request flits onto the memory bus and packs bus responses
// into response flits, with range check and response credits

`include "mem_tile_config.svh"
`default_nettype none

module noc_endpoint
  import noc_pkg::*;
  import mem_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  id_t           id_i,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  input  noc_req_flit_t req_flit_i,
  output logic          rsp_valid_o,
  input  logic          rsp_ready_i,
  output noc_rsp_flit_t rsp_flit_o,
  output logic          mem_req_o,
  input  logic          mem_gnt_i,
  output mem_req_t      mem_req_data_o,
  input  logic          mem_rvalid_i,
  input  mem_rsp_t      mem_rsp_i
);

  localparam int unsigned Depth     = `MEM_TILE_FIFO_DEPTH;
  localparam int unsigned CntW      = $clog2(Depth + 1);
  localparam int unsigned PtrW      = $clog2(Depth);
  localparam int unsigned ByteOffW  = $clog2(`MEM_TILE_DATA_W / 8);
  localparam int unsigned LaneBytes = `MEM_TILE_DATA_W / 16;
  localparam logic [`MEM_TILE_ADDR_W-1:0] TileBytes = `MEM_TILE_BYTES;

  typedef struct packed {
    id_t  src_id;
    txn_t txn_id;
  } tag_t;

  noc_req_flit_t   head;
  noc_rsp_flit_t   rsp_push;
  logic            head_valid, head_pop, head_oor;
  logic            credit_ok, bus_take, oor_take;
  logic [CntW-1:0] credits_q, inflight_q;
  tag_t            tag_q [Depth];
  logic [PtrW-1:0] tag_wr_q, tag_rd_q;

  //////////////////////////////
  // Request side
  //////////////////////////////

  stream_fifo #(
    .Depth    (Depth),
    .payload_t(noc_req_flit_t)
  ) i_req_fifo (
    .clk_i,
    .rst_n_i,
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_i (req_flit_i),
    .valid_o(head_valid),
    .ready_i(head_pop),
    .data_o (head)
  );

  assign head_oor  = head.addr >= TileBytes;
  assign credit_ok = credits_q < CntW'(Depth);
  assign mem_req_o = head_valid & ~head_oor & credit_ok;
  assign bus_take  = mem_req_o & mem_gnt_i;
  // Error flits bypass the bus once nothing is in flight
  assign oor_take  = head_valid & head_oor & credit_ok & (inflight_q == '0);
  assign head_pop  = bus_take | oor_take;

  always_comb begin
    mem_req_data_o.addr   = head.addr[`MEM_TILE_ADDR_W-1:ByteOffW];
    mem_req_data_o.we     = head.op == noc_write;
    mem_req_data_o.wdata  = head.wdata;
    mem_req_data_o.be     = head.be;
    mem_req_data_o.atop   = atop_none;
    mem_req_data_o.src_id = head.src_id;
    // Atomic lane from address bit 2
    if (head.op == noc_atomic) begin
      mem_req_data_o.atop = head.atop;
      mem_req_data_o.be   = {{LaneBytes{head.addr[2]}}, {LaneBytes{~head.addr[2]}}};
    end
  end

  // In-order ids of requests on the bus
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tag_wr_q   <= '0;
      tag_rd_q   <= '0;
      inflight_q <= '0;
      credits_q  <= '0;
    end else begin
      if (bus_take) begin
        tag_wr_q <= (tag_wr_q == PtrW'(Depth - 1)) ? '0 : tag_wr_q + 1'b1;
      end
      if (mem_rvalid_i) begin
        tag_rd_q <= (tag_rd_q == PtrW'(Depth - 1)) ? '0 : tag_rd_q + 1'b1;
      end
      inflight_q <= inflight_q + CntW'(bus_take) - CntW'(mem_rvalid_i);
      credits_q  <= credits_q + CntW'(head_pop) - CntW'(rsp_valid_o & rsp_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_take) begin
      tag_q[tag_wr_q] <= '{src_id: head.src_id, txn_id: head.txn_id};
    end
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  always_comb begin
    rsp_push.src_id = id_i;
    if (mem_rvalid_i) begin
      rsp_push.dst_id = tag_q[tag_rd_q].src_id;
      rsp_push.txn_id = tag_q[tag_rd_q].txn_id;
      rsp_push.rdata  = mem_rsp_i.rdata;
      rsp_push.err    = mem_rsp_i.err;
    end else begin
      rsp_push.dst_id = head.src_id;
      rsp_push.txn_id = head.txn_id;
      rsp_push.rdata  = '0;
      rsp_push.err    = 1'b1;
    end
  end

  // Credits keep this FIFO from overflowing
  stream_fifo #(
    .Depth    (Depth),
    .payload_t(noc_rsp_flit_t)
  ) i_rsp_fifo (
    .clk_i,
    .rst_n_i,
    .valid_i(mem_rvalid_i | oor_take),
    .ready_o(),
    .data_i (rsp_push),
    .valid_o(rsp_valid_o),
    .ready_i(rsp_ready_i),
    .data_o (rsp_flit_o)
  );

endmodule

`default_nettype wire

// File: source/stream_fifo.sv
// Stream FIFO
// Valid/ready buffer of any payload type, circular storage

`default_nettype none

module stream_fifo #(
  parameter int unsigned Depth     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  localparam int unsigned PtrW = $clog2(Depth);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            push, pop;

  assign ready_o = count_q != (PtrW + 1)'(Depth);
  assign valid_o = count_q != '0;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: sram_bank/sram_banks.sv
// SRAM bank array
// Splits each bus word over bank columns and selects one macro row
// by address, read data comes back one cycle later

`include "mem_tile_config.svh"
`default_nettype none

module sram_banks
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  output logic     gnt_o,
  input  mem_req_t req_data_i,
  output logic     rvalid_o,
  output mem_rsp_t rsp_o
);

  localparam int unsigned Cols       = `MEM_TILE_BANKS_PER_WORD;
  localparam int unsigned Rows       = `MEM_TILE_BANK_ROWS;
  localparam int unsigned SramW      = `MEM_TILE_SRAM_DATA_W;
  localparam int unsigned MacroAddrW = $clog2(`MEM_TILE_SRAM_WORDS);
  localparam int unsigned RowSelW    = $clog2(Rows);

  logic [MacroAddrW-1:0]               macro_addr;
  logic [RowSelW-1:0]                  row_sel, row_sel_q;
  logic [Rows-1:0][Cols-1:0][SramW-1:0] rdata_split;

  assign gnt_o      = 1'b1;
  assign macro_addr = req_data_i.addr[MacroAddrW-1:0];
  assign row_sel    = req_data_i.addr[MacroAddrW+:RowSelW];

  // Row of the last read picks the read data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_o  <= 1'b0;
      row_sel_q <= '0;
    end else begin
      rvalid_o <= req_i & gnt_o;
      if (req_i && !req_data_i.we) begin
        row_sel_q <= row_sel;
      end
    end
  end

  always_comb begin
    rsp_o.err = 1'b0;
    for (int unsigned c = 0; c < Cols; c++) begin
      rsp_o.rdata[c*SramW+:SramW] = rdata_split[row_sel_q][c];
    end
  end

  for (genvar c = 0; c < Cols; c++) begin : gen_cols
    for (genvar r = 0; r < Rows; r++) begin : gen_rows
      sram_macro i_sram_macro (
        .clk_i,
        .req_i  (req_i && (row_sel == RowSelW'(r))),
        .we_i   (req_data_i.we),
        .addr_i (macro_addr),
        .wdata_i(req_data_i.wdata[c*SramW+:SramW]),
        .be_i   (req_data_i.be[c*SramW/8+:SramW/8]),
        .rdata_o(rdata_split[r][c])
      );
    end
  end

endmodule

`default_nettype wire

// File: sram_bank/sram_macro.sv
// SRAM macro model
// Single port, byte enables, registered read data

`include "mem_tile_config.svh"
`default_nettype none

module sram_macro (
  input  logic                                     clk_i,
  input  logic                                     req_i,
  input  logic                                     we_i,
  input  logic [$clog2(`MEM_TILE_SRAM_WORDS)-1:0] addr_i,
  input  logic [`MEM_TILE_SRAM_DATA_W-1:0]         wdata_i,
  input  logic [`MEM_TILE_SRAM_DATA_W/8-1:0]       be_i,
  output logic [`MEM_TILE_SRAM_DATA_W-1:0]         rdata_o
);

  logic [`MEM_TILE_SRAM_DATA_W-1:0] mem_q [`MEM_TILE_SRAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < `MEM_TILE_SRAM_DATA_W / 8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8+:8] <= wdata_i[b*8+:8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/mem_pkg.sv
common/noc_pkg.sv
source/stream_fifo.sv
source/noc_endpoint.sv
atop_resolver/atop_resolver.sv
sram_bank/sram_macro.sv
sram_bank/sram_banks.sv
source/mem_tile.sv
dv/tb_mem_tile.sv
